// ==== gat_accel.f ====
+incdir+bench
verilog/gat_pkg.sv
verilog/feature_mem.sv
verilog/weight_mem.sv
verilog/sparse_row_reader.sv
verilog/wh_mac.sv
verilog/wh_bram.sv
verilog/gat_top.sv
bench/tb_gat_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GAT WH-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_gat_top -f gat_accel.f

./obj_dir/Vtb_gat_top > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// ==== bench/gat_model.svh ====
/*
 * WH reference model
 * Expected WH element from the bench copies of H, row lengths and W
 */
`ifndef GAT_MODEL_SVH
`define GAT_MODEL_SVH

// First H entry of a node, entries are packed in node order
function automatic int row_start(input int node);
  int start;
  start = 0;
  for (int n = 0; n < node; n++) begin
    start += row_len[n];
  end
  return start;
endfunction

// Sum of value x weight over the row, clipped to the WH range
function automatic int expected_wh(input int node, input int feat);
  int start;
  int acc;
  int wh_max;
  int wh_min;
  start  = row_start(node);
  acc    = 0;
  wh_max = (1 <<< (WH_DATA_WIDTH - 1)) - 1;
  wh_min = -(1 <<< (WH_DATA_WIDTH - 1));
  for (int e = 0; e < row_len[node]; e++) begin
    acc += h_val[start + e] * wgt[h_col[start + e]][feat];
  end
  if (acc > wh_max) begin
    return wh_max;
  end else if (acc < wh_min) begin
    return wh_min;
  end
  return acc;
endfunction

`endif

// ==== bench/tb_gat_top.sv ====
/*
 * Testbench for the GAT WH = H x W stage
 * Loads sparse H, row lengths and W, runs the core and
 * checks every WH element against a reference model
 */
`timescale 1ns/10ps

module tb_gat_top
  import gat_pkg::*;
();

  localparam int TOTAL_NODES       = 16;
  localparam int NUM_FEATURE_IN    = 11;
  localparam int NUM_FEATURE_OUT   = 16;
  localparam int H_NUM_SPARSE_DATA = 128;
  localparam int WH_DATA_WIDTH     = 11;

  localparam int COL_IDX_W   = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1);
  localparam int H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA);
  localparam int NODE_ADDR_W = $clog2(TOTAL_NODES);
  localparam int WGT_ADDR_W  = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT);
  localparam int WH_ADDR_W   = $clog2(TOTAL_NODES * NUM_FEATURE_OUT);

  localparam int NUM_TESTS   = 5;
  localparam int LOAD_WRITES = H_NUM_SPARSE_DATA + TOTAL_NODES +
                               NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int RUN_CYCLES  = TOTAL_NODES * (NUM_FEATURE_IN + 4);
  localparam int READS       = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int WATCHDOG_CYCLES = 2 * NUM_TESTS * (LOAD_WRITES + RUN_CYCLES + READS + 60);

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic [DATA_WIDTH+COL_IDX_W-1:0]     h_data_bram_din;
  logic                                h_data_bram_ena;
  logic                                h_data_bram_wea;
  logic [H_ADDR_W-1:0]                 h_data_bram_addra;
  logic [ROW_LEN_W-1:0]                h_node_info_bram_din;
  logic                                h_node_info_bram_ena;
  logic                                h_node_info_bram_wea;
  logic [NODE_ADDR_W-1:0]              h_node_info_bram_addra;
  logic [DATA_WIDTH-1:0]               wgt_bram_din;
  logic                                wgt_bram_ena;
  logic                                wgt_bram_wea;
  logic [WGT_ADDR_W-1:0]               wgt_bram_addra;
  logic                                h_data_bram_load_done;
  logic                                h_node_info_bram_load_done;
  logic                                wgt_bram_load_done;
  logic [WH_ADDR_W-1:0]                wh_out_bram_addrb;
  logic signed [WH_DATA_WIDTH-1:0]     wh_out_bram_dout;
  logic                                gat_ready;

  // Bench copies of the loaded data
  int row_len [TOTAL_NODES];
  int h_val   [H_NUM_SPARSE_DATA];
  int h_col   [H_NUM_SPARSE_DATA];
  int wgt     [NUM_FEATURE_IN][NUM_FEATURE_OUT];

  // Read request and its copy one clock later
  logic rd_issue  = 1'b0;
  int   rd_node   = 0;
  int   rd_feat   = 0;
  logic cmp_valid = 1'b0;
  int   cmp_node  = 0;
  int   cmp_feat  = 0;

  int check_count = 0;
  int error_count = 0;

  `include "gat_model.svh"

  gat_top #(
    .TOTAL_NODES       (TOTAL_NODES),
    .NUM_FEATURE_IN    (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT   (NUM_FEATURE_OUT),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA),
    .WH_DATA_WIDTH     (WH_DATA_WIDTH)
  ) UUT (.*);

  always #2 clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic int rand_byte();
    logic [DATA_WIDTH-1:0] r;
    r = DATA_WIDTH'($urandom);
    return int'($signed(r));
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_value("gat_ready", gat_ready, 0);
  endtask

  // Mode 0 random sparse, 1 every odd node empty, 2 dense at the extremes
  task automatic build_case(input int mode);
    int budget;
    int len;
    int addr;
    int j;
    int tmp;
    int perm [NUM_FEATURE_IN];
    budget = H_NUM_SPARSE_DATA;
    addr   = 0;
    for (int i = 0; i < NUM_FEATURE_IN; i++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        if (mode == 2) begin
          wgt[i][f] = (f % 2 == 0) ? -(1 <<< (DATA_WIDTH - 1)) : (1 <<< (DATA_WIDTH - 1)) - 1;
        end else begin
          wgt[i][f] = rand_byte();
        end
      end
    end
    for (int n = 0; n < TOTAL_NODES; n++) begin
      if (mode == 2) begin
        len = NUM_FEATURE_IN;
      end else if (mode == 1 && n % 2 == 1) begin
        len = 0;
      end else begin
        len = $urandom_range(NUM_FEATURE_IN, 0);
      end
      // H memory holds fewer entries than a fully dense H
      if (len > budget) begin
        len = budget;
      end
      row_len[n] = len;
      budget -= len;
      for (int k = 0; k < NUM_FEATURE_IN; k++) begin
        perm[k] = k;
      end
      for (int k = NUM_FEATURE_IN - 1; k > 0 && mode != 2; k--) begin
        j       = $urandom_range(k, 0);
        tmp     = perm[k];
        perm[k] = perm[j];
        perm[j] = tmp;
      end
      for (int k = 0; k < len; k++) begin
        h_col[addr] = perm[k];
        if (mode == 2) begin
          h_val[addr] = (n % 2 == 0) ? -(1 <<< (DATA_WIDTH - 1)) : (1 <<< (DATA_WIDTH - 1)) - 1;
        end else begin
          h_val[addr] = rand_byte();
        end
        addr++;
      end
    end
    for (int a = addr; a < H_NUM_SPARSE_DATA; a++) begin
      h_val[a] = (a * 37 + 5) % (1 << DATA_WIDTH) - (1 << (DATA_WIDTH - 1));
      h_col[a] = a % NUM_FEATURE_IN;
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < H_NUM_SPARSE_DATA; a++) begin
      @(negedge clk);
      h_data_bram_ena   = 1'b1;
      h_data_bram_wea   = 1'b1;
      h_data_bram_addra = H_ADDR_W'(a);
      h_data_bram_din   = {DATA_WIDTH'(h_val[a]), COL_IDX_W'(h_col[a])};
    end
    @(negedge clk);
    h_data_bram_ena = 1'b0;
    h_data_bram_wea = 1'b0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      h_node_info_bram_ena   = 1'b1;
      h_node_info_bram_wea   = 1'b1;
      h_node_info_bram_addra = NODE_ADDR_W'(n);
      h_node_info_bram_din   = ROW_LEN_W'(row_len[n]);
      @(negedge clk);
    end
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    for (int i = 0; i < NUM_FEATURE_IN; i++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        wgt_bram_ena   = 1'b1;
        wgt_bram_wea   = 1'b1;
        wgt_bram_addra = WGT_ADDR_W'(i * NUM_FEATURE_OUT + f);
        wgt_bram_din   = DATA_WIDTH'(wgt[i][f]);
        @(negedge clk);
      end
    end
    wgt_bram_ena = 1'b0;
    wgt_bram_wea = 1'b0;
  endtask

  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (gat_ready !== 1'b1) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic read_all();
    for (int n = 0; n < TOTAL_NODES; n++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        @(negedge clk);
        rd_issue          = 1'b1;
        rd_node           = n;
        rd_feat           = f;
        wh_out_bram_addrb = WH_ADDR_W'(n * NUM_FEATURE_OUT + f);
      end
    end
    @(negedge clk);
    rd_issue = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic run_case(input int mode);
    int cycles;
    apply_reset();
    build_case(mode);
    load_memories();
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    wgt_bram_load_done         = 1'b1;
    wait_ready(cycles);
    read_all();
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d mismatches", num, name, error_count - errs_before);
    end
  endtask

  // ==============================
  // Compare process
  // ==============================
  always @(posedge clk) begin
    cmp_valid <= rd_issue;
    cmp_node  <= rd_node;
    cmp_feat  <= rd_feat;
  end

  always @(negedge clk) begin
    if (cmp_valid) begin
      if (row_len[cmp_node] == 0) begin
        check_value("wh_out_bram_dout", int'(wh_out_bram_dout), 0);
      end else begin
        check_value("wh_out_bram_dout", int'(wh_out_bram_dout),
                    expected_wh(cmp_node, cmp_feat));
      end
    end
  end

  // ==============================
  // Tests
  // ==============================
  initial begin
    int errs;
    int ready_cycles;
    void'($urandom(32'h40a0_3b15));
    rst_n                      = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    wh_out_bram_addrb          = '0;

    // Weight load-done held back
    errs = error_count;
    apply_reset();
    build_case(0);
    load_memories();
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    repeat (50) begin
      @(negedge clk);
      check_value("gat_ready", gat_ready, 0);
    end
    wgt_bram_load_done = 1'b1;
    wait_ready(ready_cycles);
    // Every node costs two cycles plus its entries once the walk starts
    check_count++;
    if (ready_cycles < 2 * TOTAL_NODES + row_start(TOTAL_NODES)) begin
      error_count++;
      $display("gat_ready rose %0d cycles after the weight load-done, too early for a full walk",
               ready_cycles);
    end
    end_test(1, "ready gated by load-done", errs);

    errs = error_count;
    run_case(0);
    end_test(2, "random sparse H", errs);

    errs = error_count;
    run_case(1);
    end_test(3, "empty rows read zero", errs);

    errs = error_count;
    run_case(2);
    end_test(4, "dense extremes saturate", errs);

    errs = error_count;
    run_case(0);
    check_value("gat_ready", gat_ready, 1);
    end_test(5, "reload after reset", errs);

    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count,
             error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 4);
    $display("timeout: gat_ready never rose within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog/gat_top.sv ====
/*
 * GAT accelerator top level, WH = H x W stage
 * Host loads H, node info and W, the core streams sparse rows
 * through the MAC and the host reads back saturated WH elements
 */
`timescale 1ns/10ps

module gat_top
  import gat_pkg::*;
#(
  parameter TOTAL_NODES       = 16,
  parameter NUM_FEATURE_IN    = 11,
  parameter NUM_FEATURE_OUT   = 16,
  parameter H_NUM_SPARSE_DATA = 128,
  parameter WH_DATA_WIDTH     = 11,

  localparam COL_IDX_W   = $clog2(NUM_FEATURE_IN),
  localparam ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam H_DATA_W    = DATA_WIDTH + COL_IDX_W,
  localparam H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam NODE_ADDR_W = $clog2(TOTAL_NODES),
  localparam WGT_ADDR_W  = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam WH_ADDR_W   = $clog2(TOTAL_NODES * NUM_FEATURE_OUT),
  localparam ACC_W       = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN + 1)
)(
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic [H_DATA_W-1:0]             h_data_bram_din,
  input  logic                            h_data_bram_ena,
  input  logic                            h_data_bram_wea,
  input  logic [H_ADDR_W-1:0]             h_data_bram_addra,

  input  logic [ROW_LEN_W-1:0]            h_node_info_bram_din,
  input  logic                            h_node_info_bram_ena,
  input  logic                            h_node_info_bram_wea,
  input  logic [NODE_ADDR_W-1:0]          h_node_info_bram_addra,

  input  logic [DATA_WIDTH-1:0]           wgt_bram_din,
  input  logic                            wgt_bram_ena,
  input  logic                            wgt_bram_wea,
  input  logic [WGT_ADDR_W-1:0]           wgt_bram_addra,

  input  logic                            h_data_bram_load_done,
  input  logic                            h_node_info_bram_load_done,
  input  logic                            wgt_bram_load_done,

  input  logic [WH_ADDR_W-1:0]            wh_out_bram_addrb,
  output logic signed [WH_DATA_WIDTH-1:0] wh_out_bram_dout,
  output logic                            gat_ready
);

  // ==============================
  // Internal paths
  // ==============================
  logic [H_ADDR_W-1:0]                         h_data_addrb;
  logic [H_DATA_W-1:0]                         h_data_dout;
  logic [NODE_ADDR_W-1:0]                      h_node_info_addrb;
  logic [ROW_LEN_W-1:0]                        h_node_info_dout;

  logic                                        nz_valid;
  logic [DATA_WIDTH-1:0]                       nz_value;
  logic [COL_IDX_W-1:0]                        nz_col;
  logic                                        nz_last;

  logic [COL_IDX_W-1:0]                        wgt_row_addr;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]  wgt_row;

  logic                                        wh_wr_en;
  logic [NODE_ADDR_W-1:0]                      wh_wr_node;
  logic [NUM_FEATURE_OUT-1:0][ACC_W-1:0]       wh_wr_row;

  feature_mem #(
    .TOTAL_NODES       (TOTAL_NODES),
    .NUM_FEATURE_IN    (NUM_FEATURE_IN),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) u_feature_mem (.*);

  weight_mem #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_weight_mem (.*);

  sparse_row_reader #(
    .TOTAL_NODES       (TOTAL_NODES),
    .NUM_FEATURE_IN    (NUM_FEATURE_IN),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) u_sparse_row_reader (.*);

  // MAC row counter doubles as the ready level
  wh_mac #(
    .TOTAL_NODES     (TOTAL_NODES),
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_wh_mac (
    .*,
    .rows_done (gat_ready)
  );

  wh_bram #(
    .TOTAL_NODES     (TOTAL_NODES),
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .WH_DATA_WIDTH   (WH_DATA_WIDTH)
  ) u_wh_bram (.*);

endmodule

// ==== verilog/wh_bram.sv ====
/*
 * WH result memory
 * Clips each accumulated row to the WH width and
 * serves single elements to the host
 */
`timescale 1ns/10ps

module wh_bram
  import gat_pkg::*;
#(
  parameter TOTAL_NODES     = 16,
  parameter NUM_FEATURE_IN  = 11,
  parameter NUM_FEATURE_OUT = 16,
  parameter WH_DATA_WIDTH   = 11,

  localparam NODE_ADDR_W = $clog2(TOTAL_NODES),
  localparam FEAT_W      = $clog2(NUM_FEATURE_OUT),
  localparam WH_ADDR_W   = $clog2(TOTAL_NODES * NUM_FEATURE_OUT),
  localparam ACC_W       = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN + 1)
)(
  input  logic                                  clk,

  input  logic                                  wh_wr_en,
  input  logic [NODE_ADDR_W-1:0]                wh_wr_node,
  input  logic [NUM_FEATURE_OUT-1:0][ACC_W-1:0] wh_wr_row,

  input  logic [WH_ADDR_W-1:0]                  wh_out_bram_addrb,
  output logic signed [WH_DATA_WIDTH-1:0]       wh_out_bram_dout
);

  localparam logic signed [63:0] WH_MAX = sat_max(WH_DATA_WIDTH);
  localparam logic signed [63:0] WH_MIN = sat_min(WH_DATA_WIDTH);

  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] mem [TOTAL_NODES];
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] sat_row;
  logic [NODE_ADDR_W-1:0]                        rd_node;
  logic [FEAT_W-1:0]                             rd_feat;

  always_comb begin
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      if ($signed(wh_wr_row[f]) > WH_MAX) begin
        sat_row[f] = WH_MAX[WH_DATA_WIDTH-1:0];
      end else if ($signed(wh_wr_row[f]) < WH_MIN) begin
        sat_row[f] = WH_MIN[WH_DATA_WIDTH-1:0];
      end else begin
        sat_row[f] = wh_wr_row[f][WH_DATA_WIDTH-1:0];
      end
    end
  end

  // Host address is node * NUM_FEATURE_OUT + feature
  assign rd_node = NODE_ADDR_W'(wh_out_bram_addrb / NUM_FEATURE_OUT);
  assign rd_feat = FEAT_W'(wh_out_bram_addrb % NUM_FEATURE_OUT);

  always_ff @(posedge clk) begin
    if (wh_wr_en) begin
      mem[wh_wr_node] <= sat_row;
    end
    wh_out_bram_dout <= mem[rd_node][rd_feat];
  end

endmodule

// ==== verilog/wh_mac.sv ====
/*
 * WH multiply-accumulate
 * Fetches the weight row of each entry's column and adds
 * value x weight into one accumulator per output feature
 */
`timescale 1ns/10ps

module wh_mac
  import gat_pkg::*;
#(
  parameter TOTAL_NODES     = 16,
  parameter NUM_FEATURE_IN  = 11,
  parameter NUM_FEATURE_OUT = 16,

  localparam COL_IDX_W   = $clog2(NUM_FEATURE_IN),
  localparam NODE_ADDR_W = $clog2(TOTAL_NODES),
  localparam ACC_W       = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN + 1)
)(
  input  logic                                       clk,
  input  logic                                       rst_n,

  input  logic                                       nz_valid,
  input  logic [DATA_WIDTH-1:0]                      nz_value,
  input  logic [COL_IDX_W-1:0]                       nz_col,
  input  logic                                       nz_last,

  output logic [COL_IDX_W-1:0]                       wgt_row_addr,
  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] wgt_row,

  output logic                                       wh_wr_en,
  output logic [NODE_ADDR_W-1:0]                     wh_wr_node,
  output logic [NUM_FEATURE_OUT-1:0][ACC_W-1:0]      wh_wr_row,
  output logic                                       rows_done
);

  logic                    s1_valid;
  logic                    s1_last;
  logic signed [DATA_WIDTH-1:0] s1_value;
  logic                    acc_clear;
  logic signed [ACC_W-1:0] acc [NUM_FEATURE_OUT];
  logic signed [ACC_W-1:0] sum [NUM_FEATURE_OUT];

  // ==============================
  // Stage 1, weight row fetch
  // ==============================
  assign wgt_row_addr = nz_col;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= nz_valid;
      s1_last  <= nz_valid && nz_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_value <= nz_value;
  end

  // ==============================
  // Stage 2, multiply-accumulate
  // ==============================
  always_comb begin
    logic signed [2*DATA_WIDTH-1:0] prod;
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      prod   = s1_value * $signed(wgt_row[f]);
      sum[f] = acc_clear ? ACC_W'(prod) : acc[f] + ACC_W'(prod);
      wh_wr_row[f] = sum[f];
    end
  end

  // Row goes out in the cycle of its last entry
  assign wh_wr_en = s1_valid && s1_last;

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      acc <= sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_clear  <= 1'b1;
      wh_wr_node <= '0;
      rows_done  <= 1'b0;
    end else if (s1_valid) begin
      acc_clear <= s1_last;
      if (s1_last) begin
        wh_wr_node <= wh_wr_node + 1'b1;
        if (wh_wr_node == NODE_ADDR_W'(TOTAL_NODES - 1)) begin
          rows_done <= 1'b1;
        end
      end
    end
  end

  // Reader must fall silent once every row is written
  a_no_strobe_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    rows_done |-> !nz_valid);

endmodule

// ==== verilog/sparse_row_reader.sv ====
/*
 * Sparse row reader
 * Walks node rows once all memories are loaded and
 * streams each nonzero H entry to the MAC
 */
`timescale 1ns/10ps

module sparse_row_reader
  import gat_pkg::*;
#(
  parameter TOTAL_NODES       = 16,
  parameter NUM_FEATURE_IN    = 11,
  parameter H_NUM_SPARSE_DATA = 128,

  localparam COL_IDX_W   = $clog2(NUM_FEATURE_IN),
  localparam ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam H_DATA_W    = DATA_WIDTH + COL_IDX_W,
  localparam H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam NODE_ADDR_W = $clog2(TOTAL_NODES)
)(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   h_data_bram_load_done,
  input  logic                   h_node_info_bram_load_done,
  input  logic                   wgt_bram_load_done,

  output logic [NODE_ADDR_W-1:0] h_node_info_addrb,
  input  logic [ROW_LEN_W-1:0]   h_node_info_dout,
  output logic [H_ADDR_W-1:0]    h_data_addrb,
  input  logic [H_DATA_W-1:0]    h_data_dout,

  output logic                   nz_valid,
  output logic [DATA_WIDTH-1:0]  nz_value,
  output logic [COL_IDX_W-1:0]   nz_col,
  output logic                   nz_last
);

  reader_state_e          state;
  logic [NODE_ADDR_W-1:0] node_idx;
  logic [H_ADDR_W:0]      h_addr;     // extra bit so an overrun is visible
  logic [ROW_LEN_W-1:0]   ent_cnt;
  logic                   all_loaded;
  logic                   rd_issue;
  logic                   row_end;
  logic                   empty_row;

  assign all_loaded = h_data_bram_load_done && h_node_info_bram_load_done &&
                      wgt_bram_load_done;

  // Row length stays on the node-info output for the whole row
  assign rd_issue = (state == STREAM) && (h_node_info_dout != '0);
  assign row_end  = (h_node_info_dout == '0) || (ent_cnt == h_node_info_dout - 1'b1);

  assign h_node_info_addrb = node_idx;
  assign h_data_addrb      = h_addr[H_ADDR_W-1:0];

  // ==============================
  // Row walk FSM
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      node_idx <= '0;
      h_addr   <= '0;
      ent_cnt  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (all_loaded) begin
            state <= INFO;
          end
        end
        INFO: begin
          state <= STREAM;
        end
        STREAM: begin
          if (rd_issue) begin
            h_addr <= h_addr + 1'b1;
          end
          if (row_end) begin
            ent_cnt <= '0;
            state   <= NEXT;
          end else begin
            ent_cnt <= ent_cnt + 1'b1;
          end
        end
        NEXT: begin
          node_idx <= node_idx + 1'b1;
          state    <= (node_idx == NODE_ADDR_W'(TOTAL_NODES - 1)) ? DONE : INFO;
        end
        DONE: begin
          state <= DONE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Strobe lines up with the registered H read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nz_valid  <= 1'b0;
      nz_last   <= 1'b0;
      empty_row <= 1'b0;
    end else begin
      nz_valid  <= (state == STREAM);
      nz_last   <= (state == STREAM) && row_end;
      empty_row <= (state == STREAM) && (h_node_info_dout == '0);
    end
  end

  // Empty row sends one zero entry
  assign nz_value = empty_row ? '0 : h_data_dout[H_DATA_W-1 -: DATA_WIDTH];
  assign nz_col   = empty_row ? '0 : h_data_dout[COL_IDX_W-1:0];

  // Running H address must stay inside the loaded entries
  a_h_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    rd_issue |-> h_addr < H_NUM_SPARSE_DATA);

endmodule

// ==== verilog/weight_mem.sv ====
/*
 * Weight memory
 * Host writes single weights, the MAC reads a full
 * row of NUM_FEATURE_OUT weights per input feature
 */
`timescale 1ns/10ps

module weight_mem
  import gat_pkg::*;
#(
  parameter NUM_FEATURE_IN  = 11,
  parameter NUM_FEATURE_OUT = 16,

  localparam COL_IDX_W  = $clog2(NUM_FEATURE_IN),
  localparam FEAT_W     = $clog2(NUM_FEATURE_OUT),
  localparam WGT_ADDR_W = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT)
)(
  input  logic                                       clk,

  input  logic [DATA_WIDTH-1:0]                      wgt_bram_din,
  input  logic                                       wgt_bram_ena,
  input  logic                                       wgt_bram_wea,
  input  logic [WGT_ADDR_W-1:0]                      wgt_bram_addra,

  input  logic [COL_IDX_W-1:0]                       wgt_row_addr,
  output logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] wgt_row
);

  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] mem [NUM_FEATURE_IN];
  logic [COL_IDX_W-1:0]                       wr_row;
  logic [FEAT_W-1:0]                          wr_lane;

  // Host address is row * NUM_FEATURE_OUT + column
  assign wr_row  = COL_IDX_W'(wgt_bram_addra / NUM_FEATURE_OUT);
  assign wr_lane = FEAT_W'(wgt_bram_addra % NUM_FEATURE_OUT);

  always_ff @(posedge clk) begin
    if (wgt_bram_ena && wgt_bram_wea) begin
      mem[wr_row][wr_lane] <= wgt_bram_din;
    end
    wgt_row <= mem[wgt_row_addr];
  end

endmodule

// ==== verilog/feature_mem.sv ====
/*
 * Sparse feature memories
 * H entries (value, column) and per-node row lengths,
 * host write ports and registered reads for the row reader
 */
`timescale 1ns/10ps

module feature_mem
  import gat_pkg::*;
#(
  parameter TOTAL_NODES       = 16,
  parameter NUM_FEATURE_IN    = 11,
  parameter H_NUM_SPARSE_DATA = 128,

  localparam COL_IDX_W   = $clog2(NUM_FEATURE_IN),
  localparam ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam H_DATA_W    = DATA_WIDTH + COL_IDX_W,
  localparam H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam NODE_ADDR_W = $clog2(TOTAL_NODES)
)(
  input  logic                   clk,

  input  logic [H_DATA_W-1:0]    h_data_bram_din,
  input  logic                   h_data_bram_ena,
  input  logic                   h_data_bram_wea,
  input  logic [H_ADDR_W-1:0]    h_data_bram_addra,

  input  logic [ROW_LEN_W-1:0]   h_node_info_bram_din,
  input  logic                   h_node_info_bram_ena,
  input  logic                   h_node_info_bram_wea,
  input  logic [NODE_ADDR_W-1:0] h_node_info_bram_addra,

  input  logic [H_ADDR_W-1:0]    h_data_addrb,
  input  logic [NODE_ADDR_W-1:0] h_node_info_addrb,
  output logic [H_DATA_W-1:0]    h_data_dout,
  output logic [ROW_LEN_W-1:0]   h_node_info_dout
);

  logic [H_DATA_W-1:0]  h_data_mem    [H_NUM_SPARSE_DATA];
  logic [ROW_LEN_W-1:0] node_info_mem [TOTAL_NODES];

  always_ff @(posedge clk) begin
    if (h_data_bram_ena && h_data_bram_wea) begin
      h_data_mem[h_data_bram_addra] <= h_data_bram_din;
    end
    h_data_dout <= h_data_mem[h_data_addrb];
  end

  always_ff @(posedge clk) begin
    if (h_node_info_bram_ena && h_node_info_bram_wea) begin
      node_info_mem[h_node_info_bram_addra] <= h_node_info_bram_din;
    end
    h_node_info_dout <= node_info_mem[h_node_info_addrb];
  end

  // Host loads stay inside both memories
  a_h_data_wr_range: assert property (@(posedge clk)
    h_data_bram_ena && h_data_bram_wea |-> h_data_bram_addra < H_NUM_SPARSE_DATA);
  a_node_info_wr_range: assert property (@(posedge clk)
    h_node_info_bram_ena && h_node_info_bram_wea |-> h_node_info_bram_addra < TOTAL_NODES);

endmodule

// ==== verilog/gat_pkg.sv ====
/*
 * GAT accelerator shared definitions
 * Data width, sparse reader states and WH saturation limits
 */
package gat_pkg;

  // Signed feature value and weight
  localparam int DATA_WIDTH = 8;

  // ==============================
  // Sparse row reader states
  // ==============================
  typedef enum logic [2:0] {
    IDLE,
    INFO,
    STREAM,
    NEXT,
    DONE
  } reader_state_e;

  // Largest signed value held in width bits
  function automatic logic signed [63:0] sat_max(input int width);
    return (64'sd1 <<< (width - 1)) - 64'sd1;
  endfunction

  // Smallest signed value held in width bits
  function automatic logic signed [63:0] sat_min(input int width);
    return -(64'sd1 <<< (width - 1));
  endfunction

endpackage
